//--- hdl/vga_gain_pkg.sv
// amplifier gain controller shared definitions
// channel count, SPI timing, LMH6401 gain register and frame layout
`default_nettype none

package vga_gain_pkg;

  // number of LMH6401 amplifiers on the board, one chip select each
  localparam int num_channels = 2;

  // width of a channel index, kept at least one bit wide
  localparam int chan_bits = (num_channels > 1) ? $clog2(num_channels) : 1;

  // clk cycles per sck period, must be even
  localparam int clk_div = 10;

  // LMH6401 gain code width
  localparam int gain_bits = 6;

  // gain register inside the amplifier
  localparam logic [6:0] gain_reg_addr = 7'h02;

  // one SPI transaction is rw + address + data
  localparam int frame_bits = 16;

  // writer FSM state codes
  localparam logic [1:0] wr_idle = 2'd0;
  localparam logic [1:0] wr_sending = 2'd1;
  localparam logic [1:0] wr_finish = 2'd2;

  // LMH6401 frame as seen by the register block (fields) and the shifter (raw)
  // rw sits in the MSB and goes out first on the wire
  typedef union packed {
    // shift word, MSB first
    logic [frame_bits-1:0] raw;
    struct packed {
      // 1 = read, 0 = write
      logic       rw;
      // register address
      logic [6:0] reg_addr;
      // register data, gain code in the low bits
      logic [7:0] data;
    } fields;
  } lmh_frame_u;

endpackage

`default_nettype wire

//--- hdl/vga_gain_regs.sv
// gain register block for the LMH6401 bank
// keeps a shadow gain and pending flag per channel and issues
// round-robin write frames to the SPI writer
`default_nettype none
`timescale 1ns/10ps

module vga_gain_regs (
  input  wire                                   clk,
  input  wire                                   reset,
  // host side, single-cycle strobe, never back-pressured
  input  wire                                   gain_wr,
  input  wire  [vga_gain_pkg::chan_bits-1:0]    gain_ch,
  input  wire  [vga_gain_pkg::gain_bits-1:0]    gain_value,
  // request to the SPI writer
  input  wire                                   cmd_ready,
  output logic                                  cmd_valid,
  output logic [vga_gain_pkg::chan_bits-1:0]    cmd_channel,
  output vga_gain_pkg::lmh_frame_u              cmd_frame
);

  // per-channel shadow gains and pending flags
  logic [vga_gain_pkg::gain_bits-1:0]    shadow [vga_gain_pkg::num_channels];
  logic [vga_gain_pkg::num_channels-1:0] pending;

  // channel served by the last transfer, search starts one past it
  logic [vga_gain_pkg::chan_bits-1:0]    last_ch;

  // round-robin pick
  logic                                  pick_found;
  logic [vga_gain_pkg::chan_bits-1:0]    pick_ch;
  logic [vga_gain_pkg::gain_bits-1:0]    pick_gain;

  // frame built from the picked channel
  vga_gain_pkg::lmh_frame_u              next_frame;

  // handshake events
  logic                                  xfer;
  logic                                  launch;

  assign xfer = cmd_valid && cmd_ready;

  // only start a request while the writer sits idle and nothing is held,
  // so strobes arriving during a frame fold into the shadow instead
  assign launch = !cmd_valid && cmd_ready && pick_found;

  // search pending flags starting one after the last served channel
  // wrap around so every channel gets a turn
  always_comb begin : rr_pick
    int idx;
    idx = 0;
    pick_found = 1'b0;
    pick_ch = '0;
    for (int k = 1; k <= vga_gain_pkg::num_channels; k++) begin
      idx = (int'(last_ch) + k) % vga_gain_pkg::num_channels;
      if (!pick_found && pending[idx]) begin
        pick_found = 1'b1;
        pick_ch = vga_gain_pkg::chan_bits'(idx);
      end
    end
  end

  // a strobe to the picked channel in the launch cycle lands in the shadow
  // on the same edge, so take the host value directly
  assign pick_gain = (gain_wr && gain_ch == pick_ch) ? gain_value : shadow[pick_ch];

  // gain register write frame
  always_comb begin
    next_frame = '0;
    next_frame.fields.rw = 1'b0;
    next_frame.fields.reg_addr = vga_gain_pkg::gain_reg_addr;
    // zero-extended gain code
    next_frame.fields.data = 8'(pick_gain);
  end

  // shadow gains and pending flags
  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= '0;
      for (int ch = 0; ch < vga_gain_pkg::num_channels; ch++) begin
        shadow[ch] <= '0;
      end
    end else begin
      for (int ch = 0; ch < vga_gain_pkg::num_channels; ch++) begin
        if (gain_wr && gain_ch == vga_gain_pkg::chan_bits'(ch)) begin
          // latest write wins, also keeps the flag set across a transfer
          shadow[ch] <= gain_value;
          pending[ch] <= 1'b1;
        end else if (xfer && cmd_channel == vga_gain_pkg::chan_bits'(ch)) begin
          pending[ch] <= 1'b0;
        end
      end
    end
  end

  // round-robin pointer follows the channel actually handed over
  always_ff @(posedge clk) begin
    if (reset) begin
      // first search starts at channel 0
      last_ch <= vga_gain_pkg::chan_bits'(vga_gain_pkg::num_channels - 1);
    end else if (xfer) begin
      last_ch <= cmd_channel;
    end
  end

  // request valid, held until the writer takes it
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_valid <= 1'b0;
    end else if (launch) begin
      cmd_valid <= 1'b1;
    end else if (xfer) begin
      cmd_valid <= 1'b0;
    end
  end

  // request payload, loaded only at launch so it is stable while held
  always_ff @(posedge clk) begin
    if (launch) begin
      cmd_channel <= pick_ch;
      cmd_frame <= next_frame;
    end
  end

endmodule

`default_nettype wire

//--- hdl/lmh6401_spi_writer.sv
// write-only SPI shifter for the LMH6401 bank
// divides clk down to sck and sends one 16-bit frame MSB first
// under the chip select of the requested channel
`default_nettype none
`timescale 1ns/10ps

module lmh6401_spi_writer (
  input  wire                                      clk,
  input  wire                                      reset,
  // frame request from the register block
  input  wire                                      cmd_valid,
  input  wire  [vga_gain_pkg::chan_bits-1:0]       cmd_channel,
  input  wire  vga_gain_pkg::lmh_frame_u           cmd_frame,
  output logic                                     cmd_ready,
  // SPI pins, one active-low select per amplifier
  output logic                                     sck,
  output logic                                     sdi,
  output logic [vga_gain_pkg::num_channels-1:0]    cs_n
);

  // sck divider
  logic [$clog2(vga_gain_pkg::clk_div)-1:0] div_cnt;
  logic                                     half_done;
  logic                                     sck_fall;

  // frame FSM
  logic [1:0]                               state;
  logic [vga_gain_pkg::chan_bits-1:0]       chan_q;
  logic [vga_gain_pkg::frame_bits-1:0]      shift_q;
  logic [$clog2(vga_gain_pkg::frame_bits)-1:0] bit_cnt;
  logic                                     xfer;

  // request with the rw bit forced to write
  vga_gain_pkg::lmh_frame_u                 write_frame;

  // end of a half sck period
  assign half_done = int'(div_cnt) == vga_gain_pkg::clk_div / 2 - 1;

  // sck is about to drop, so data may change on this edge
  assign sck_fall = sck && half_done;

  // accept a new frame only while idle
  assign cmd_ready = state == vga_gain_pkg::wr_idle;
  assign xfer = cmd_valid && cmd_ready;

  // never let a stray rw bit turn the transfer into a read
  always_comb begin
    write_frame = cmd_frame;
    write_frame.fields.rw = 1'b0;
  end

  // free-running sck
  always_ff @(posedge clk) begin
    if (reset) begin
      div_cnt <= '0;
      sck <= 1'b0;
    end else if (half_done) begin
      div_cnt <= '0;
      sck <= ~sck;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // frame FSM and pins
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= vga_gain_pkg::wr_idle;
      bit_cnt <= '0;
      cs_n <= '1;
      sdi <= 1'b0;
    end else begin
      case (state)
        vga_gain_pkg::wr_idle: begin
          if (xfer) begin
            state <= vga_gain_pkg::wr_sending;
          end
        end
        vga_gain_pkg::wr_sending: begin
          // select drops together with the first bit
          if (sck_fall) begin
            cs_n[chan_q] <= 1'b0;
            sdi <= shift_q[vga_gain_pkg::frame_bits-1];
            bit_cnt <= bit_cnt + 1'b1;
            if (int'(bit_cnt) == vga_gain_pkg::frame_bits - 1) begin
              state <= vga_gain_pkg::wr_finish;
            end
          end
        end
        vga_gain_pkg::wr_finish: begin
          // one falling edge after bit 0 the select is released
          if (sck_fall) begin
            cs_n <= '1;
            sdi <= 1'b0;
            bit_cnt <= '0;
            state <= vga_gain_pkg::wr_idle;
          end
        end
        default: begin
          state <= vga_gain_pkg::wr_idle;
          cs_n <= '1;
        end
      endcase
    end
  end

  // channel and shift word, loaded on transfer and shifted MSB first
  always_ff @(posedge clk) begin
    if (xfer) begin
      chan_q <= cmd_channel;
      shift_q <= write_frame.raw;
    end else if (state == vga_gain_pkg::wr_sending && sck_fall) begin
      shift_q <= {shift_q[vga_gain_pkg::frame_bits-2:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

//--- hdl/vga_gain_ctrl.sv
// LMH6401 gain controller top
// host gain strobes go through the register block and out over SPI
`default_nettype none
`timescale 1ns/10ps

module vga_gain_ctrl (
  input  wire                                   clk,
  input  wire                                   reset,
  // host gain write, single-cycle strobe
  input  wire                                   gain_wr,
  input  wire  [vga_gain_pkg::chan_bits-1:0]    gain_ch,
  input  wire  [vga_gain_pkg::gain_bits-1:0]    gain_value,
  // amplifier SPI pins
  output logic                                  sck,
  output logic                                  sdi,
  output logic [vga_gain_pkg::num_channels-1:0] cs_n
);

  // request path between the two blocks
  logic                                  cmd_valid;
  logic                                  cmd_ready;
  logic [vga_gain_pkg::chan_bits-1:0]    cmd_channel;
  vga_gain_pkg::lmh_frame_u              cmd_frame;

  // shadow gains, pending flags and round-robin frame builder
  vga_gain_regs vga_gain_regs_i (
    .clk         (clk),
    .reset       (reset),
    .gain_wr     (gain_wr),
    .gain_ch     (gain_ch),
    .gain_value  (gain_value),
    .cmd_ready   (cmd_ready),
    .cmd_valid   (cmd_valid),
    .cmd_channel (cmd_channel),
    .cmd_frame   (cmd_frame)
  );

  // sck divider and frame shifter
  lmh6401_spi_writer lmh6401_spi_writer_i (
    .clk         (clk),
    .reset       (reset),
    .cmd_valid   (cmd_valid),
    .cmd_channel (cmd_channel),
    .cmd_frame   (cmd_frame),
    .cmd_ready   (cmd_ready),
    .sck         (sck),
    .sdi         (sdi),
    .cs_n        (cs_n)
  );

endmodule

`default_nettype wire

//--- tb/lmh6401_spi_model.sv
// LMH6401 receiver model
// shifts in sdi on rising sck under an active select, reports each frame when it closes
`default_nettype none
`timescale 1ns/10ps

module lmh6401_spi_model (
  input  wire                                   clk,
  input  wire                                   reset,
  input  wire                                   sck,
  input  wire                                   sdi,
  input  wire  [vga_gain_pkg::num_channels-1:0] cs_n,
  // one-cycle report of a finished frame
  output logic                                  frame_done,
  output logic [vga_gain_pkg::chan_bits-1:0]    frame_ch,
  output logic [vga_gain_pkg::frame_bits-1:0]   frame_word,
  output logic [7:0]                            frame_nbits
);

  // pin history for edge detection
  logic                                  sck_q;
  logic [vga_gain_pkg::num_channels-1:0] cs_n_q;
  // bits received in the open frame
  logic [vga_gain_pkg::frame_bits-1:0]   shift_in;
  logic [7:0]                            nbits;

  always_ff @(posedge clk) begin
    if (reset) begin
      sck_q <= 1'b0;
      cs_n_q <= '1;
      shift_in <= '0;
      nbits <= '0;
      frame_done <= 1'b0;
      frame_ch <= '0;
      frame_word <= '0;
      frame_nbits <= '0;
    end else begin
      sck_q <= sck;
      cs_n_q <= cs_n;
      frame_done <= 1'b0;
      // amplifier latches sdi on the rising sck edge
      if (sck && !sck_q && cs_n != '1) begin
        shift_in <= {shift_in[vga_gain_pkg::frame_bits-2:0], sdi};
        nbits <= nbits + 8'd1;
      end
      // select released, the frame is complete
      for (int ch = 0; ch < vga_gain_pkg::num_channels; ch++) begin
        if (!cs_n_q[ch] && cs_n[ch]) begin
          frame_done <= 1'b1;
          frame_ch <= vga_gain_pkg::chan_bits'(ch);
          frame_word <= shift_in;
          frame_nbits <= nbits;
          shift_in <= '0;
          nbits <= '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tb/vga_gain_ctrl_assert.sv
// protocol checks on the LMH6401 SPI writer
// chip select exclusivity, busy handshake, sdi timing and request timing
`default_nettype none
`timescale 1ns/10ps

module vga_gain_ctrl_assert (
  input wire                                   clk,
  input wire                                   reset,
  input wire                                   cmd_valid,
  input wire                                   cmd_ready,
  input wire                                   sck,
  input wire                                   sdi,
  input wire  [vga_gain_pkg::num_channels-1:0] cs_n
);

  // failed assertion count, read by the testbench at the end
  int unsigned fail_count = 0;

  // only one amplifier selected at a time
  one_select: assert property (@(posedge clk) disable iff (reset)
    $countones(~cs_n) <= 1)
    else begin
      $error("more than one chip select is low");
      fail_count++;
    end

  // writer is busy for the whole frame
  busy_while_selected: assert property (@(posedge clk) disable iff (reset)
    (cs_n != '1) |-> !cmd_ready)
    else begin
      $error("cmd_ready is high while a chip select is low");
      fail_count++;
    end

  // data only moves on falling sck
  sdi_stable_high: assert property (@(posedge clk) disable iff (reset)
    (sck && $past(sck)) |-> $stable(sdi))
    else begin
      $error("sdi changed while sck was high");
      fail_count++;
    end

  // requests only go to an idle writer, so a payload is never held stale
  // while later strobes land in the shadow
  request_to_idle: assert property (@(posedge clk) disable iff (reset)
    cmd_valid |-> cmd_ready)
    else begin
      $error("request raised while the writer was busy");
      fail_count++;
    end

endmodule

bind lmh6401_spi_writer vga_gain_ctrl_assert vga_gain_ctrl_assert_i (
  .clk         (clk),
  .reset       (reset),
  .cmd_valid   (cmd_valid),
  .cmd_ready   (cmd_ready),
  .sck         (sck),
  .sdi         (sdi),
  .cs_n        (cs_n)
);

`default_nettype wire

//--- tb/vga_gain_ctrl_tb.sv
// testbench for the LMH6401 gain controller
// host gain writes in, every SPI frame checked against a shadow of the gains
`default_nettype none
`timescale 1ns/10ps

module vga_gain_ctrl_tb;

  localparam int clk_period = 10;
  // a frame plus phase wait fits inside 20 sck periods
  localparam int frame_cycles = 20 * vga_gain_pkg::clk_div;
  localparam int quiet_cycles = 2 * frame_cycles;
  localparam int rr_rounds = 4;
  localparam int random_writes = 40;
  localparam int total_writes = 6 + 2 * rr_rounds + 1 + random_writes;

  logic                                  clk = 1'b0;
  logic                                  reset;
  logic                                  gain_wr;
  logic [vga_gain_pkg::chan_bits-1:0]    gain_ch;
  logic [vga_gain_pkg::gain_bits-1:0]    gain_value;
  wire                                   sck;
  wire                                   sdi;
  wire  [vga_gain_pkg::num_channels-1:0] cs_n;
  logic                                  frame_done;
  logic [vga_gain_pkg::chan_bits-1:0]    frame_ch;
  logic [vga_gain_pkg::frame_bits-1:0]   frame_word;
  logic [7:0]                            frame_nbits;

  // expected gains and captured frames
  logic [vga_gain_pkg::gain_bits-1:0]    shadow [vga_gain_pkg::num_channels];
  logic [vga_gain_pkg::frame_bits-1:0]   last_word [vga_gain_pkg::num_channels];
  logic [vga_gain_pkg::chan_bits-1:0]    got_ch_q [$];
  logic [vga_gain_pkg::frame_bits-1:0]   got_word_q [$];
  logic [7:0]                            got_nbits_q [$];
  logic [31:0]                           rand_state = 32'hef70_1bdc;
  int                                    errors = 0;
  int                                    test_errors;
  int                                    tests_passed = 0;

  always #(clk_period / 2) clk = ~clk;

  vga_gain_ctrl vga_gain_ctrl_i (
    .clk        (clk),
    .reset      (reset),
    .gain_wr    (gain_wr),
    .gain_ch    (gain_ch),
    .gain_value (gain_value),
    .sck        (sck),
    .sdi        (sdi),
    .cs_n       (cs_n)
  );

  lmh6401_spi_model spi_model_i (
    .clk         (clk),
    .reset       (reset),
    .sck         (sck),
    .sdi         (sdi),
    .cs_n        (cs_n),
    .frame_done  (frame_done),
    .frame_ch    (frame_ch),
    .frame_word  (frame_word),
    .frame_nbits (frame_nbits)
  );

  // log every frame the amplifier model closes
  always @(posedge clk) begin
    if (frame_done) begin
      got_ch_q.push_back(frame_ch);
      got_word_q.push_back(frame_word);
      got_nbits_q.push_back(frame_nbits);
      last_word[frame_ch] = frame_word;
    end
  end

  // xorshift32 step
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rand_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rand_state = x;
    return x;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    assert (got === expected)
      else begin
        $display("Error: %s is 0x%0h, expected 0x%0h", name, got, expected);
        errors++;
      end
  endtask

  // one strobe, shadow follows the host
  task automatic write_gain(input int ch, input logic [vga_gain_pkg::gain_bits-1:0] value);
    @(posedge clk);
    gain_wr <= 1'b1;
    gain_ch <= vga_gain_pkg::chan_bits'(ch);
    gain_value <= value;
    shadow[ch] = value;
    @(posedge clk);
    gain_wr <= 1'b0;
  endtask

  // wait for a select to drop, return its channel
  task automatic wait_select_low(output int ch);
    int waited;
    waited = 0;
    ch = -1;
    do begin
      @(negedge clk);
      waited++;
    end while (cs_n == '1 && waited < frame_cycles);
    for (int c = 0; c < vga_gain_pkg::num_channels; c++) begin
      if (!cs_n[c]) ch = c;
    end
    if (ch < 0) begin
      $display("no chip select went low within %0d cycles", frame_cycles);
      errors++;
    end
  endtask

  task automatic wait_select_high();
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (cs_n != '1 && waited < frame_cycles);
    if (cs_n != '1) begin
      $display("a chip select stayed low for more than %0d cycles", frame_cycles);
      errors++;
    end
  endtask

  // done once the pins stay idle and no frame arrives for a while
  task automatic wait_quiet();
    int quiet;
    int waited;
    int seen;
    quiet = 0;
    waited = 0;
    seen = got_ch_q.size();
    while (quiet < quiet_cycles && waited < 10 * frame_cycles) begin
      @(negedge clk);
      waited++;
      if (cs_n != '1 || got_ch_q.size() != seen) begin
        quiet = 0;
        seen = got_ch_q.size();
      end else begin
        quiet++;
      end
    end
    if (quiet < quiet_cycles) begin
      $display("SPI traffic did not drain in time");
      errors++;
    end
  endtask

  // wire order: 0, gain register address, gain zero-extended to 8 bits
  task automatic check_frame(input int idx, input int exp_ch,
                             input logic [vga_gain_pkg::gain_bits-1:0] exp_gain);
    if (idx >= got_ch_q.size()) begin
      $display("frame %0d was never captured", idx);
      errors++;
    end else begin
      check_value("frame_ch", got_ch_q[idx], exp_ch);
      check_value("frame_nbits", got_nbits_q[idx], vga_gain_pkg::frame_bits);
      check_value("frame rw", got_word_q[idx][15], 0);
      check_value("frame reg_addr", got_word_q[idx][14:8], vga_gain_pkg::gain_reg_addr);
      check_value("frame data", got_word_q[idx][7:0], {2'b00, exp_gain});
    end
  endtask

  task automatic finish_test(input int num, input string name);
    if (errors == test_errors) begin
      $display("test %0d %s: passed", num, name);
      tests_passed++;
    end else begin
      $display("test %0d %s: failed with %0d errors", num, name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  initial begin : main
    int base;
    int ch;
    int gap;
    int exp_ch [rr_rounds + 2];
    logic [vga_gain_pkg::gain_bits-1:0] exp_gain [rr_rounds + 2];
    logic [vga_gain_pkg::gain_bits-1:0] first_gain;
    reset = 1'b1;
    gain_wr = 1'b0;
    gain_ch = '0;
    gain_value = '0;
    for (int c = 0; c < vga_gain_pkg::num_channels; c++) begin
      shadow[c] = '0;
      last_word[c] = '0;
    end
    test_errors = 0;

    // 1: idle pins in reset, no frame without a write
    repeat (8) @(posedge clk);
    check_value("cs_n", cs_n, {vga_gain_pkg::num_channels{1'b1}});
    check_value("sck", sck, 0);
    check_value("sdi", sdi, 0);
    reset <= 1'b0;
    wait_quiet();
    check_value("frame count", got_ch_q.size(), 0);
    finish_test(1, "reset state");

    // 2: one write per channel gives one frame each
    for (int c = 0; c < vga_gain_pkg::num_channels; c++) begin
      base = got_ch_q.size();
      write_gain(c, 6'(next_random()));
      wait_quiet();
      check_value("frame count", got_ch_q.size(), base + 1);
      check_frame(base, c, shadow[c]);
    end
    finish_test(2, "single writes");

    // 3: rewrites of channel 1 while channel 0 is busy fold into one frame
    base = got_ch_q.size();
    write_gain(0, 6'(next_random()));
    first_gain = shadow[0];
    wait_select_low(ch);
    check_value("busy channel", ch, 0);
    repeat (3) write_gain(1, 6'(next_random()));
    wait_quiet();
    check_value("frame count", got_ch_q.size(), base + 2);
    check_frame(base, 0, first_gain);
    check_frame(base + 1, 1, shadow[1]);
    finish_test(3, "latest value wins");

    // 4: both channels kept pending, service alternates
    base = got_ch_q.size();
    write_gain(0, 6'(next_random()));
    for (int k = 0; k < rr_rounds + 2; k++) begin
      wait_select_low(ch);
      exp_ch[k] = ch;
      // payload is fixed before the select drops
      exp_gain[k] = (ch >= 0) ? shadow[ch] : '0;
      if (k < rr_rounds) begin
        write_gain(0, 6'(next_random()));
        write_gain(1, 6'(next_random()));
      end
      wait_select_high();
    end
    wait_quiet();
    check_value("frame count", got_ch_q.size(), base + rr_rounds + 2);
    for (int k = 0; k < rr_rounds + 2; k++) begin
      check_value("round-robin channel", exp_ch[k], k % 2);
      check_frame(base + k, k % 2, exp_gain[k]);
    end
    finish_test(4, "round-robin");

    // 5: random traffic, last frame per channel matches the shadow
    base = got_ch_q.size();
    for (int i = 0; i < random_writes; i++) begin
      gap = int'(next_random() % 64);
      repeat (gap) @(posedge clk);
      write_gain(int'(next_random() % vga_gain_pkg::num_channels), 6'(next_random()));
    end
    wait_quiet();
    for (int i = base; i < got_ch_q.size(); i++) begin
      check_value("frame_nbits", got_nbits_q[i], vga_gain_pkg::frame_bits);
      check_value("frame rw", got_word_q[i][15], 0);
      check_value("frame reg_addr", got_word_q[i][14:8], vga_gain_pkg::gain_reg_addr);
    end
    for (int c = 0; c < vga_gain_pkg::num_channels; c++) begin
      check_value($sformatf("last data ch%0d", c), last_word[c][7:0], {2'b00, shadow[c]});
    end
    finish_test(5, "random writes");

    if (vga_gain_ctrl_i.lmh6401_spi_writer_i.vga_gain_ctrl_assert_i.fail_count != 0) begin
      $display("protocol assertions failed %0d times",
               vga_gain_ctrl_i.lmh6401_spi_writer_i.vga_gain_ctrl_assert_i.fail_count);
      errors++;
    end
    $display("tests run 5, passed %0d, failed %0d, errors %0d",
             tests_passed, 5 - tests_passed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // bound from the write count, with room for the idle windows
  initial begin : watchdog
    #((total_writes + 20) * frame_cycles * clk_period);
    $display("watchdog expired before the tests completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
hdl/vga_gain_pkg.sv
hdl/vga_gain_regs.sv
hdl/lmh6401_spi_writer.sv
hdl/vga_gain_ctrl.sv
tb/lmh6401_spi_model.sv
tb/vga_gain_ctrl_assert.sv
tb/vga_gain_ctrl_tb.sv
